// File: core_io_pkg.sv
/*
 * core-side types of the host bridge
 * config word, joystick, status, change counter, key event, ioctl fields
 */
`include "host_bridge_params.svh"

package core_io_pkg;

	// raw config word from the host
	typedef logic [`HB_IO_W-1:0] cfg_word_t;

	// two bus words each
	typedef logic [2*`HB_IO_W-1:0] joystick_t;

	typedef logic [`HB_STATUS_WORDS*`HB_IO_W-1:0] status_t;

	// status change counter
	typedef logic [`HB_STFLG_W-1:0] stflg_t;

	// toggle flips on every published event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	// download port
	typedef logic [`HB_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [`HB_DATA_W-1:0] ioctl_data_t;
	typedef logic [`HB_IO_W-1:0]   ioctl_index_t;

endpackage

// File: file_loader.sv
/*
 * file channel framing and download port
 * file index, download start and stop, start address, data stream
 * with a write strobe two clocks after the data strobe
 */
`timescale 1ns/1ps
`include "host_bridge_params.svh"

module file_loader (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        io_strobe,
	input  logic                        fp_enable,
	input  host_cmd_pkg::io_word_t      io_din,
	output logic                        ioctl_download,
	output logic                        ioctl_wr,
	output core_io_pkg::ioctl_index_t   ioctl_index,
	output core_io_pkg::ioctl_addr_t    ioctl_addr,
	output core_io_pkg::ioctl_data_t    ioctl_dout,
	output host_cmd_pkg::io_word_t      fp_dout
);
	import host_cmd_pkg::*;
	import core_io_pkg::*;

	word_idx_t   word_cnt;
	io_word_t    fcmd;
	ioctl_addr_t addr;
	logic        wr_pend;
	logic        fp_strobe;
	logic        arg_strobe;
	logic        tx_start;
	logic        dat_strobe;
	logic [7:0]  start_code;

	// no upload path, the host always reads zero here
	assign fp_dout = '0;

	assign fp_strobe  = fp_enable & io_strobe;
	assign arg_strobe = fp_strobe & (word_cnt != '0);
	assign start_code = io_din[7:0];
	assign tx_start   = arg_strobe & (fcmd == FIO_FILE_TX) & (word_cnt == 1);
	assign dat_strobe = arg_strobe & (fcmd == FIO_FILE_TX_DAT) & ioctl_download;

	//////////////////////////////////////////////////////////////////////
	// framing and download state
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt       <= '0;
			fcmd           <= '0;
			ioctl_download <= 1'b0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			wr_pend  <= dat_strobe;
			ioctl_wr <= wr_pend;

			if (!fp_enable) begin
				word_cnt <= '0;
				fcmd     <= '0;
			end else if (io_strobe) begin
				if (word_cnt == '0) begin
					fcmd <= io_din;
				end
				if (~&word_cnt) begin
					word_cnt <= word_cnt + 1'b1;
				end
			end

			// upload code is reserved, nothing happens for it
			if (tx_start) begin
				if (start_code == '0) begin
					ioctl_download <= 1'b0;
				end else if (start_code != `HB_TX_UPLOAD_CODE) begin
					ioctl_download <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// index, address and data
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (arg_strobe) begin
			case (fcmd)
				FIO_FILE_INDEX: begin
					ioctl_index <= io_din;
				end
				FIO_FILE_TX: begin
					case (word_cnt)
						1: begin
							if (start_code == '0) begin
								// leave the final address visible after the stop
								if (ioctl_download) begin
									ioctl_addr <= addr;
								end
							end else if (start_code != `HB_TX_UPLOAD_CODE) begin
								addr <= '0;
							end
						end
						2: begin
							ioctl_addr[`HB_IO_W-1:0] <= io_din;
							addr[`HB_IO_W-1:0]       <= io_din;
						end
						3: begin
							ioctl_addr[`HB_ADDR_W-1:`HB_IO_W] <= io_din[`HB_ADDR_W-`HB_IO_W-1:0];
							addr[`HB_ADDR_W-1:`HB_IO_W]       <= io_din[`HB_ADDR_W-`HB_IO_W-1:0];
						end
						default: ;
					endcase
				end
				FIO_FILE_TX_DAT: begin
					if (ioctl_download) begin
						ioctl_addr <= addr;
						ioctl_dout <= io_din[`HB_DATA_W-1:0];
						addr       <= addr + ioctl_addr_t'(`HB_ADDR_STEP);
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: host_bridge.f
+incdir+.
host_cmd_pkg.sv
core_io_pkg.sv
host_cmd_frame.sv
host_cfg_regs.sv
ps2_key_decoder.sv
file_loader.sv
host_bridge.sv
tb_host_bridge.sv

// File: host_bridge.sv
/*
 * host to core command bridge, top level
 * control framing, register block, keyboard decoder, file loader,
 * readback select between the two channels
 */
`timescale 1ns/1ps

module host_bridge (
	input  logic                        clk_sys,
	input  logic                        rst_n,

	// host bus
	input  logic                        io_strobe,
	input  logic                        io_enable,
	input  logic                        fp_enable,
	input  host_cmd_pkg::io_word_t      io_din,
	output host_cmd_pkg::io_word_t      io_dout,

	// core registers and events
	output logic [1:0]                  buttons,
	output logic                        forced_scandoubler,
	output logic                        direct_video,
	output core_io_pkg::joystick_t      joystick_0,
	output core_io_pkg::joystick_t      joystick_1,
	output core_io_pkg::status_t        status,
	input  core_io_pkg::status_t        status_in,
	input  logic                        status_set,
	output core_io_pkg::key_event_t     ps2_key,

	// download port
	output logic                        ioctl_download,
	output core_io_pkg::ioctl_index_t   ioctl_index,
	output logic                        ioctl_wr,
	output core_io_pkg::ioctl_addr_t    ioctl_addr,
	output core_io_pkg::ioctl_data_t    ioctl_dout
);
	import host_cmd_pkg::*;

	logic      cmd_valid;
	logic      arg_valid;
	logic      frame_end;
	io_word_t  cmd;
	word_idx_t arg_idx;
	io_word_t  ctl_dout;
	io_word_t  fp_dout;

	host_cmd_frame u_frame (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.io_din    (io_din),
		.cmd_valid (cmd_valid),
		.arg_valid (arg_valid),
		.frame_end (frame_end),
		.cmd       (cmd),
		.arg_idx   (arg_idx)
	);

	host_cfg_regs u_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.cmd_valid          (cmd_valid),
		.arg_valid          (arg_valid),
		.io_enable          (io_enable),
		.status_set         (status_set),
		.cmd                (cmd),
		.io_din             (io_din),
		.arg_idx            (arg_idx),
		.status_in          (status_in),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ctl_dout           (ctl_dout)
	);

	ps2_key_decoder u_kbd (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.arg_valid (arg_valid),
		.frame_end (frame_end),
		.cmd       (cmd),
		.io_din    (io_din),
		.ps2_key   (ps2_key)
	);

	file_loader u_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.io_strobe      (io_strobe),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.fp_dout        (fp_dout)
	);

	// file channel owns the bus while fp_enable is high
	assign io_dout = fp_enable ? fp_dout : ctl_dout;

endmodule

// File: host_bridge_params.svh
/*
 * host bridge shared constants
 * bus word and frame index widths, status reply tag, scancode skip marker,
 * download address and data widths, address step, reserved upload code
 */
`ifndef HOST_BRIDGE_PARAMS_SVH
`define HOST_BRIDGE_PARAMS_SVH

// host bus
`define HB_IO_W             16
`define HB_IDX_W            4

// status register and change request
`define HB_STFLG_W          4
`define HB_STATUS_WORDS     4
`define HB_STFLG_TAG        4'hA

// keyboard frames
`define HB_SKIP_MARK        8'hFF

// download port
`define HB_ADDR_W           27
`define HB_DATA_W           8
`define HB_ADDR_STEP        1
`define HB_TX_UPLOAD_CODE   8'hAA

`endif

// File: host_cfg_regs.sv
/*
 * control channel register block
 * config word, two joysticks, 64-bit status, status change request
 * with counter and snapshot, registered control reply word
 */
`timescale 1ns/1ps
`include "host_bridge_params.svh"

module host_cfg_regs (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    cmd_valid,
	input  logic                    arg_valid,
	input  logic                    io_enable,
	input  logic                    status_set,
	input  host_cmd_pkg::io_word_t  cmd,
	input  host_cmd_pkg::io_word_t  io_din,
	input  host_cmd_pkg::word_idx_t arg_idx,
	input  core_io_pkg::status_t    status_in,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output core_io_pkg::joystick_t  joystick_0,
	output core_io_pkg::joystick_t  joystick_1,
	output core_io_pkg::status_t    status,
	output host_cmd_pkg::io_word_t  ctl_dout
);
	import host_cmd_pkg::*;
	import core_io_pkg::*;

	// zero bits between tag and counter in the request reply
	localparam int REPLY_PAD = `HB_IO_W - 4 - `HB_STFLG_W;

	cfg_word_t cfg;
	stflg_t    stflg;
	status_t   status_req;
	logic      status_set_d;
	logic      status_rise;
	word_idx_t part_sel;
	logic      part_ok;
	io_word_t  status_reply;

	// the remaining config bits are handled outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	assign status_rise  = status_set & ~status_set_d;
	assign status_reply = {`HB_STFLG_TAG, {REPLY_PAD{1'b0}}, stflg};

	// arguments 1..4 map to 16-bit parts, lowest first
	assign part_sel = arg_idx - 1'b1;
	assign part_ok  = (arg_idx <= `HB_STATUS_WORDS);

	//////////////////////////////////////////////////////////////////////
	// host written registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (arg_valid) begin
			case (cmd)
				CMD_CFG: begin
					cfg <= io_din;
				end
				CMD_JOY0: begin
					if (arg_idx == 1) begin
						joystick_0[`HB_IO_W-1:0] <= io_din;
					end else if (arg_idx == 2) begin
						joystick_0[2*`HB_IO_W-1:`HB_IO_W] <= io_din;
					end
				end
				CMD_JOY1: begin
					if (arg_idx == 1) begin
						joystick_1[`HB_IO_W-1:0] <= io_din;
					end else if (arg_idx == 2) begin
						joystick_1[2*`HB_IO_W-1:`HB_IO_W] <= io_din;
					end
				end
				CMD_STATUS: begin
					if (part_ok) begin
						status[part_sel*`HB_IO_W +: `HB_IO_W] <= io_din;
					end
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// core status change request
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_rise) begin
				stflg <= stflg + 1'b1;
			end
		end
	end

	// snapshot of status_in taken with each counted edge
	always_ff @(posedge clk_sys) begin
		if (status_rise) begin
			status_req <= status_in;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reply word, answers the strobe one clock later
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ctl_dout <= '0;
		end else if (!io_enable) begin
			ctl_dout <= '0;
		end else if (cmd_valid) begin
			// command word is still on io_din here
			ctl_dout <= (io_din == CMD_STATUS_REQ) ? status_reply : '0;
		end else if (arg_valid) begin
			if (cmd == CMD_STATUS_REQ && part_ok) begin
				ctl_dout <= status_req[part_sel*`HB_IO_W +: `HB_IO_W];
			end else begin
				ctl_dout <= '0;
			end
		end
	end

endmodule

// File: host_cmd_frame.sv
/*
 * control channel framing
 * command strobe, argument strobe with index, end of frame pulse
 */
`timescale 1ns/1ps

module host_cmd_frame (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    io_strobe,
	input  logic                    io_enable,
	input  host_cmd_pkg::io_word_t  io_din,
	output logic                    cmd_valid,
	output logic                    arg_valid,
	output logic                    frame_end,
	output host_cmd_pkg::io_word_t  cmd,
	output host_cmd_pkg::word_idx_t arg_idx
);
	import host_cmd_pkg::*;

	// words seen so far in this frame
	word_idx_t word_cnt;
	logic      word_strobe;

	assign word_strobe = io_enable & io_strobe;

	// on cmd_valid the command itself is on io_din, cmd follows a clock later
	assign cmd_valid = word_strobe & (word_cnt == '0);
	assign arg_valid = word_strobe & (word_cnt != '0);
	assign arg_idx   = word_cnt;

	// word_cnt is cleared at the end of this cycle, so the pulse is one cycle
	assign frame_end = ~io_enable & (word_cnt != '0);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt <= '0;
			cmd      <= '0;
		end else if (!io_enable) begin
			// idle channel
			word_cnt <= '0;
			cmd      <= '0;
		end else if (io_strobe) begin
			if (word_cnt == '0) begin
				cmd <= io_din;
			end
			// saturate, long frames keep index 15
			if (~&word_cnt) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

endmodule

// File: host_cmd_pkg.sv
/*
 * bus-side types of the host bridge
 * bus word, word index within a frame, control and file command codes
 */
`include "host_bridge_params.svh"

package host_cmd_pkg;

	// one strobed word on the host bus
	typedef logic [`HB_IO_W-1:0] io_word_t;

	// position of a word in a frame, saturates at all ones
	typedef logic [`HB_IDX_W-1:0] word_idx_t;

	////////////////////////////////////////////////////////////////////////
	// control channel commands, word 0 while io_enable is high
	////////////////////////////////////////////////////////////////////////
	typedef enum logic [`HB_IO_W-1:0] {
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_PS2_KEY    = 16'h0005,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_REQ = 16'h0029
	} host_cmd_e;

	////////////////////////////////////////////////////////////////////////
	// file channel commands, word 0 while fp_enable is high
	////////////////////////////////////////////////////////////////////////
	typedef enum logic [`HB_IO_W-1:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055
	} fio_cmd_e;

endpackage

// File: ps2_key_decoder.sv
/*
 * keyboard scancode frame decoder
 * scancode history, skip marking, key event with print-screen and pause cases
 */
`timescale 1ns/1ps
`include "host_bridge_params.svh"

module ps2_key_decoder (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    cmd_valid,
	input  logic                    arg_valid,
	input  logic                    frame_end,
	input  host_cmd_pkg::io_word_t  cmd,
	input  host_cmd_pkg::io_word_t  io_din,
	output core_io_pkg::key_event_t ps2_key
);
	import host_cmd_pkg::*;
	import core_io_pkg::*;

	localparam logic [7:0] RELEASE_MARK = 8'hF0;
	localparam logic [7:0] EXT_MARK     = 8'hE0;

	logic [31:0] key_raw;
	logic        skip;
	logic        skip_word;
	logic        key_arg;
	logic        pressed;
	logic        extended;
	key_event_t  key_next;

	assign key_arg   = arg_valid & (cmd == CMD_PS2_KEY);
	assign skip_word = (io_din[15:8] == `HB_SKIP_MARK);

	// newest byte sits in key_raw[7:0]
	assign pressed  = (key_raw[15:8] != RELEASE_MARK);
	assign extended = pressed ? (key_raw[15:8] == EXT_MARK) : (key_raw[23:16] == EXT_MARK);

	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = pressed;
		key_next.extended = extended;
		key_next.code     = key_raw[7:0];
		// multi byte keys reported as single events
		case (key_raw)
			32'hE012E07C: {key_next.pressed, key_next.extended, key_next.code} = 10'h37C;
			32'h7CE0F012: {key_next.pressed, key_next.extended, key_next.code} = 10'h17C;
			32'hF014F077: {key_next.pressed, key_next.extended, key_next.code} = 10'h377;
			default: ;
		endcase
	end

	// scancode history, cleared when a keyboard frame starts
	always_ff @(posedge clk_sys) begin
		if (cmd_valid && io_din == CMD_PS2_KEY) begin
			key_raw <= '0;
		end else if (key_arg && !skip_word && !skip) begin
			key_raw <= {key_raw[23:0], io_din[7:0]};
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (cmd_valid) begin
				skip <= 1'b0;
			end else if (key_arg && skip_word) begin
				skip <= 1'b1;
			end

			// publish once the host drops io_enable
			if (frame_end && cmd == CMD_PS2_KEY && !skip) begin
				ps2_key <= key_next;
			end
		end
	end

endmodule

// File: tb_host_bridge.sv
/*
 * directed testbench for the host bridge
 * host bus model, compare tasks, write monitor for the download port,
 * tests for reset, config, joysticks, status, status request, keys, download
 */
`timescale 1ns/1ps
`include "host_bridge_params.svh"

module tb_host_bridge;
	import host_cmd_pkg::*;
	import core_io_pkg::*;

	localparam int DL_WORDS   = 8;
	localparam int WAIT_LIMIT = 400;

	logic         clk_sys;
	logic         rst_n;
	logic         io_strobe;
	logic         io_enable;
	logic         fp_enable;
	io_word_t     io_din;
	io_word_t     io_dout;
	logic [1:0]   buttons;
	logic         forced_scandoubler;
	logic         direct_video;
	joystick_t    joystick_0;
	joystick_t    joystick_1;
	status_t      status;
	status_t      status_in;
	logic         status_set;
	key_event_t   ps2_key;
	logic         ioctl_download;
	ioctl_index_t ioctl_index;
	logic         ioctl_wr;
	ioctl_addr_t  ioctl_addr;
	ioctl_data_t  ioctl_dout;

	logic [31:0]  lcg_state = 32'd93856;
	io_word_t     frame_buf [0:15];
	ioctl_data_t  dl_data [0:DL_WORDS-1];
	int           wr_count = 0;
	int           wr_expected = 0;
	logic         key_tog = 1'b0;

	host_bridge DUT (.*);

	always #50 clk_sys = ~clk_sys;

	function automatic io_word_t lcg_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// tag A in the top nibble, change counter in the low nibble
	function automatic io_word_t req_reply(input stflg_t n);
		return 16'hA000 | io_word_t'(n);
	endfunction

	////////////////////////////////////////////////////////////////////
	// failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input io_word_t act, input io_word_t exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_joy(input string name, input joystick_t act, input joystick_t exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_status(input string name, input status_t act, input status_t exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_key(input string name, input key_event_t act, input key_event_t exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_addr(input string name, input ioctl_addr_t act, input ioctl_addr_t exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_data(input string name, input ioctl_data_t act, input ioctl_data_t exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, act, exp));
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp)
			report_failure($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, act, exp));
	endtask

	////////////////////////////////////////////////////////////////////
	// host bus model, called on a falling edge
	////////////////////////////////////////////////////////////////////
	// one strobe cycle, then two idle cycles for spacing
	task automatic strobe_word(input io_word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic read_ctl_word(input io_word_t w, output io_word_t r);
		strobe_word(w);
		r = io_dout;
	endtask

	task automatic send_ctl_frame(input int n);
		io_enable = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < n; i++)
			strobe_word(frame_buf[i]);
		io_enable = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic send_fio_frame(input int n);
		fp_enable = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < n; i++)
			strobe_word(frame_buf[i]);
		fp_enable = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// each write strobe must carry the next expected byte and address
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			if (wr_count >= wr_expected) begin
				report_failure("download write strobe seen with no data word pending");
			end else begin
				check_data("ioctl_dout", ioctl_dout, dl_data[wr_count]);
				check_addr("ioctl_addr", ioctl_addr, ioctl_addr_t'(wr_count * `HB_ADDR_STEP));
				wr_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////
	task automatic verify_reset_values();
		io_word_t r;
		check_bit("ioctl_wr", ioctl_wr, 1'b0);
		check_bit("ioctl_download", ioctl_download, 1'b0);
		check_key("ps2_key", ps2_key, '0);
		check_status("status", status, '0);
		check_joy("joystick_0", joystick_0, '0);
		check_joy("joystick_1", joystick_1, '0);
		check_word("buttons", io_word_t'(buttons), '0);
		check_bit("forced_scandoubler", forced_scandoubler, 1'b0);
		check_bit("direct_video", direct_video, 1'b0);
		check_word("io_dout", io_dout, '0);
		// counter is only visible through the request reply
		io_enable = 1'b1;
		@(negedge clk_sys);
		read_ctl_word(CMD_STATUS_REQ, r);
		check_word("io_dout", r, req_reply(0));
		io_enable = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_word("io_dout", io_dout, '0);
	endtask

	task automatic config_and_joysticks();
		io_word_t c;
		io_word_t lo;
		io_word_t hi;
		c = lcg_word();
		// second pass with every bit flipped drives each output both ways
		for (int k = 0; k < 2; k++) begin
			frame_buf[0] = CMD_CFG;
			frame_buf[1] = c;
			send_ctl_frame(2);
			check_word("buttons", io_word_t'(buttons), io_word_t'(c[1:0]));
			check_bit("forced_scandoubler", forced_scandoubler, c[4]);
			check_bit("direct_video", direct_video, c[10]);
			c = ~c;
		end
		for (int j = 0; j < 2; j++) begin
			lo = lcg_word();
			hi = lcg_word();
			frame_buf[0] = (j == 0) ? CMD_JOY0 : CMD_JOY1;
			frame_buf[1] = lo;
			frame_buf[2] = hi;
			send_ctl_frame(3);
			if (j == 0)
				check_joy("joystick_0", joystick_0, {hi, lo});
			else
				check_joy("joystick_1", joystick_1, {hi, lo});
		end
	endtask

	task automatic status_write();
		status_t exp;
		frame_buf[0] = CMD_STATUS;
		for (int i = 0; i < `HB_STATUS_WORDS; i++) begin
			frame_buf[i+1] = lcg_word();
			exp[i*`HB_IO_W +: `HB_IO_W] = frame_buf[i+1];
		end
		send_ctl_frame(`HB_STATUS_WORDS + 1);
		check_status("status", status, exp);
	endtask

	task automatic status_request();
		status_t  v;
		io_word_t r;
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < `HB_STATUS_WORDS; i++)
				v[i*`HB_IO_W +: `HB_IO_W] = lcg_word();
			status_in  = v;
			status_set = 1'b1;
			repeat (2) @(negedge clk_sys);
			status_set = 1'b0;
			repeat (2) @(negedge clk_sys);
		end
		io_enable = 1'b1;
		@(negedge clk_sys);
		read_ctl_word(CMD_STATUS_REQ, r);
		check_word("io_dout", r, req_reply(2));
		for (int i = 0; i < `HB_STATUS_WORDS; i++) begin
			read_ctl_word('0, r);
			check_word("io_dout", r, v[i*`HB_IO_W +: `HB_IO_W]);
		end
		io_enable = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// bytes of seq are sent oldest first, event expected from the flags
	task automatic key_frame(input logic [31:0] seq, input int n, input logic [9:0] pec);
		key_event_t exp;
		frame_buf[0] = CMD_PS2_KEY;
		for (int i = 0; i < n; i++)
			frame_buf[i+1] = {8'h00, seq[8*(n-1-i) +: 8]};
		send_ctl_frame(n + 1);
		key_tog = ~key_tog;
		exp = {key_tog, pec};
		check_key("ps2_key", ps2_key, exp);
	endtask

	task automatic key_events();
		key_event_t held;
		key_frame(32'h0000001C, 1, 10'h21C);
		key_frame(32'h0000F01C, 2, 10'h01C);
		key_frame(32'h0000E075, 2, 10'h375);
		key_frame(32'hE012E07C, 4, 10'h37C);
		// marked frame publishes nothing, last event stays
		held = {key_tog, 10'h37C};
		frame_buf[0] = CMD_PS2_KEY;
		frame_buf[1] = 16'h0033;
		frame_buf[2] = {`HB_SKIP_MARK, 8'h2A};
		send_ctl_frame(3);
		check_key("ps2_key", ps2_key, held);
	endtask

	task automatic download_stream();
		io_word_t idx;
		int       cycles;
		idx = lcg_word();
		frame_buf[0] = FIO_FILE_INDEX;
		frame_buf[1] = idx;
		send_fio_frame(2);
		check_word("ioctl_index", ioctl_index, idx);
		frame_buf[0] = FIO_FILE_TX;
		frame_buf[1] = 16'h0001;
		send_fio_frame(2);
		check_bit("ioctl_download", ioctl_download, 1'b1);
		wr_count     = 0;
		wr_expected  = DL_WORDS;
		frame_buf[0] = FIO_FILE_TX_DAT;
		for (int i = 0; i < DL_WORDS; i++) begin
			frame_buf[i+1] = lcg_word();
			dl_data[i]     = frame_buf[i+1][`HB_DATA_W-1:0];
		end
		send_fio_frame(DL_WORDS + 1);
		cycles = 0;
		while (wr_count < DL_WORDS && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (wr_count != DL_WORDS)
			report_failure("timed out waiting for the download write strobes");
		frame_buf[0] = FIO_FILE_TX;
		frame_buf[1] = 16'h0000;
		send_fio_frame(2);
		check_bit("ioctl_download", ioctl_download, 1'b0);
	endtask

	initial begin
		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		repeat (16) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		verify_reset_values();
		config_and_joysticks();
		status_write();
		status_request();
		key_events();
		download_stream();
		$display("RESULT: PASS");
		$finish;
	end

endmodule
